/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_tx_spw_top
FILELIST   = tx_spw_top.f
BUILD_DIR  = obj_dir
SIM_EXE    = sim_$(TOP)
LOG        = sim.log
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(SIM_EXE)
	./$(BUILD_DIR)/$(SIM_EXE) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_tx_spw_top.sv */
`include "spw_tx_consts.svh"

module tb_tx_spw_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles   = 5;
	localparam int null_cycles    = 80;
	localparam int traffic_cycles = 4000;
	localparam int stop_cycles    = 60;
	localparam int stim_cycles    = reset_cycles + null_cycles + traffic_cycles + stop_cycles;
	localparam int cycle_limit    = 20 * stim_cycles;
	localparam int pend_max       = (1 << `SPW_FCT_PEND_W) - 1;

	logic                     pclk_tx;
	logic                     enable_tx;
	logic                     send_null_tx;
	logic                     send_fct_tx;
	logic [`SPW_NCHAR_W-1:0]  tx_data_in;
	logic                     process_data;
	logic                     gotfct_tx;
	logic                     send_fct_now;
	logic [`SPW_TCODE_W-1:0]  tx_tcode_in;
	logic                     tcode_rdy_trnsp;
	logic                     ready_tx_data;
	logic                     ready_tx_timecode;
	logic [`SPW_CREDIT_W-1:0] fct_counter_p;
	logic                     tx_dout;
	logic                     tx_sout;

	// Model state
	logic [31:0]              rng;
	int                       credit_model;
	int                       credit_before;
	logic                     took_last;
	logic [`SPW_NCHAR_W-1:0]  exp_words[$];
	logic [`SPW_TCODE_W-1:0]  exp_tcodes[$];
	logic                     bitq[$];
	logic                     last_d;
	logic                     last_s;
	logic                     line_par;
	logic                     esc_pending;
	logic                     expect_flow;
	logic                     fct_enabled;
	int                       n_chars;
	int                       n_fct_dec;
	int                       fct_pulses;
	int                       n_checks;
	int                       errors;
	int                       errors_at_start;
	int                       cycles;

	tx_spw_top dut_i (
		.pclk_tx           (pclk_tx),
		.enable_tx         (enable_tx),
		.send_null_tx      (send_null_tx),
		.send_fct_tx       (send_fct_tx),
		.tx_data_in        (tx_data_in),
		.process_data      (process_data),
		.gotfct_tx         (gotfct_tx),
		.send_fct_now      (send_fct_now),
		.tx_tcode_in       (tx_tcode_in),
		.tcode_rdy_trnsp   (tcode_rdy_trnsp),
		.ready_tx_data     (ready_tx_data),
		.ready_tx_timecode (ready_tx_timecode),
		.fct_counter_p     (fct_counter_p),
		.tx_dout           (tx_dout),
		.tx_sout           (tx_sout)
	);

	always #50 pclk_tx = ~pclk_tx;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic note_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// --------------------------------------------------
	// Receiver side model
	// --------------------------------------------------
	task automatic log_char(input logic is_null);
		if (n_chars == 0)
		begin
			n_checks++;
			assert (is_null)
			else
				note_error("First character after start was not a NULL");
		end
		if (!is_null)
		begin
			n_checks++;
			assert (fct_enabled)
			else
				note_error("Character other than NULL sent before send_fct_tx");
		end
		n_chars++;
	endtask

	task automatic match_nchar(input logic [`SPW_NCHAR_W-1:0] got);
		logic [`SPW_NCHAR_W-1:0] want;
		n_checks++;
		assert (exp_words.size() > 0)
		else
			note_error($sformatf("N-char 0x%h on the line with no word taken", got));
		if (exp_words.size() > 0)
		begin
			want = exp_words.pop_front();
			n_checks++;
			assert (got == want)
			else
				note_error($sformatf("Error: tx_data_in 0x%h sent as 0x%h", want, got));
		end
	endtask

	task automatic match_tcode(input logic [`SPW_TCODE_W-1:0] got);
		logic [`SPW_TCODE_W-1:0] want;
		n_checks++;
		assert (exp_tcodes.size() > 0)
		else
			note_error($sformatf("Time-code 0x%h on the line with none taken", got));
		if (exp_tcodes.size() > 0)
		begin
			want = exp_tcodes.pop_front();
			n_checks++;
			assert (got == want)
			else
				note_error($sformatf("Error: tx_tcode_in 0x%h sent as 0x%h", want, got));
		end
	endtask

	// One character is parity, flag, then 2 or 8 bits LSB first
	task automatic take_bit(input logic b);
		logic [1:0] code;
		logic [7:0] data_v;
		int         len;
		int         i;
		bitq.push_back(b);
		if (bitq.size() < 2)
			return;
		len = bitq[1] ? `SPW_LEN_FCT : `SPW_LEN_DATA;
		if (bitq.size() < len)
			return;
		n_checks++;
		assert ((line_par ^ bitq[0] ^ bitq[1]) == 1'b1)
		else
			note_error($sformatf("Error: parity bit 0x%h after data parity 0x%h",
				bitq[0], line_par));
		if (bitq[1])
		begin
			code     = {bitq[3], bitq[2]};
			line_par = bitq[2] ^ bitq[3];
			if (code == `SPW_CODE_ESC)
			begin
				n_checks++;
				assert (!esc_pending)
				else
					note_error("Two escape characters in a row");
				esc_pending = 1'b1;
			end
			else if (esc_pending)
			begin
				// ESC then FCT is a NULL
				esc_pending = 1'b0;
				n_checks++;
				assert (code == `SPW_CODE_FCT)
				else
					note_error("Escape followed by EOP or EEP");
				log_char(1'b1);
			end
			else if (code == `SPW_CODE_FCT)
			begin
				log_char(1'b0);
				n_fct_dec++;
			end
			else
			begin
				log_char(1'b0);
				match_nchar({1'b1, 7'd0, code == `SPW_CODE_EEP});
			end
		end
		else
		begin
			for (i = 0; i < 8; i++)
				data_v[i] = bitq[i + 2];
			line_par = ^data_v;
			log_char(1'b0);
			if (esc_pending)
			begin
				esc_pending = 1'b0;
				match_tcode(data_v);
			end
			else
				match_nchar({1'b0, data_v});
		end
		bitq.delete();
	endtask

	task automatic observe_outputs();
		logic d_chg;
		logic s_chg;
		// Count now holds the strobes seen at the last edge
		if (gotfct_tx)
			credit_model = credit_model + `SPW_CREDIT_PER_FCT;
		if (took_last)
			credit_model = credit_model - 1;
		n_checks++;
		assert (int'(fct_counter_p) == credit_model)
		else
			note_error($sformatf("Error: fct_counter_p 0x%h, expected 0x%h", fct_counter_p,
				credit_model));
		if (ready_tx_data)
		begin
			n_checks++;
			assert (credit_before != 0)
			else
				note_error("Data word taken while the credit was zero");
			exp_words.push_back(tx_data_in);
		end
		if (ready_tx_timecode)
			exp_tcodes.push_back(tx_tcode_in);
		took_last     = ready_tx_data;
		credit_before = credit_model;

		d_chg  = tx_dout ^ last_d;
		s_chg  = tx_sout ^ last_s;
		last_d = tx_dout;
		last_s = tx_sout;
		n_checks++;
		assert (!(d_chg && s_chg))
		else
			note_error("Both tx_dout and tx_sout changed in one cycle");
		if (expect_flow)
		begin
			n_checks++;
			assert (d_chg || s_chg)
			else
				note_error("Lines stalled while the link was running");
		end
		if (d_chg || s_chg)
		begin
			if (send_null_tx)
				expect_flow = 1'b1;
			take_bit(tx_dout);
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge pclk_tx);
		#10;
		observe_outputs();
	endtask

	task automatic drive_inputs(input logic new_work);
		logic [31:0] r;
		logic [31:0] p;
		rng = xorshift32(rng);
		r   = rng;
		rng = xorshift32(rng);
		p   = rng;
		gotfct_tx    = 1'b0;
		send_fct_now = 1'b0;
		if (ready_tx_data)
			process_data = 1'b0;
		if (ready_tx_timecode)
			tcode_rdy_trnsp = 1'b0;
		if (new_work)
		begin
			if (!process_data && r[2:0] < 3'd3)
			begin
				process_data = 1'b1;
				if (p[11:8] == 4'd0)
					tx_data_in = 9'h100;
				else if (p[11:8] == 4'd1)
					tx_data_in = 9'h101;
				else
					tx_data_in = {1'b0, p[7:0]};
			end
			if (!tcode_rdy_trnsp && r[8:3] == 6'd0)
			begin
				tcode_rdy_trnsp = 1'b1;
				tx_tcode_in     = p[23:16];
			end
			if (r[15:9] == 7'd0 && credit_model + `SPW_CREDIT_PER_FCT <= `SPW_CREDIT_MAX)
				gotfct_tx = 1'b1;
			if (r[20:16] == 5'd0 && fct_pulses - n_fct_dec < pend_max)
			begin
				send_fct_now = 1'b1;
				fct_pulses++;
			end
		end
		// Just enough credit to flush the port while draining
		else if (process_data && credit_model == 0)
			gotfct_tx = 1'b1;
	endtask

	task automatic check_quiet();
		n_checks++;
		assert (!tx_dout && !tx_sout)
		else
			note_error($sformatf("Error: tx_dout 0x%h tx_sout 0x%h while idle",
				tx_dout, tx_sout));
		n_checks++;
		assert (!ready_tx_data && !ready_tx_timecode)
		else
			note_error($sformatf("Error: ready_tx_data 0x%h ready_tx_timecode 0x%h while idle",
				ready_tx_data, ready_tx_timecode));
		n_checks++;
		assert (fct_counter_p == '0)
		else
			note_error($sformatf("Error: fct_counter_p 0x%h while idle", fct_counter_p));
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// Watchdog
	initial
	begin
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge pclk_tx);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		int   k;
		logic held_d;
		logic held_s;
		pclk_tx         = 1'b0;
		enable_tx       = 1'b0;
		send_null_tx    = 1'b0;
		send_fct_tx     = 1'b0;
		tx_data_in      = '0;
		process_data    = 1'b0;
		gotfct_tx       = 1'b0;
		send_fct_now    = 1'b0;
		tx_tcode_in     = '0;
		tcode_rdy_trnsp = 1'b0;
		rng             = 32'h727775ba;
		credit_model    = 0;
		credit_before   = 0;
		took_last       = 1'b0;
		last_d          = 1'b0;
		last_s          = 1'b0;
		line_par        = 1'b0;
		esc_pending     = 1'b0;
		expect_flow     = 1'b0;
		fct_enabled     = 1'b0;
		n_chars         = 0;
		n_fct_dec       = 0;
		fct_pulses      = 0;
		n_checks        = 0;
		errors          = 0;
		errors_at_start = 0;

		repeat (reset_cycles)
		begin
			next_cycle();
			check_quiet();
		end
		enable_tx = 1'b1;
		repeat (3)
		begin
			next_cycle();
			check_quiet();
		end
		send_null_tx = 1'b1;
		while (n_chars == 0)
			next_cycle();
		report_test("reset");

		// NULLs only while credit, an FCT request and work pile up
		for (k = 0; k < null_cycles; k++)
		begin
			next_cycle();
			n_checks++;
			assert (!ready_tx_data && !ready_tx_timecode)
			else
				note_error("Work taken before send_fct_tx was raised");
			gotfct_tx    = (k == 4);
			send_fct_now = (k == 6);
			if (k == 6)
				fct_pulses++;
			if (k == 8)
			begin
				process_data    = 1'b1;
				tx_data_in      = 9'h0a5;
				tcode_rdy_trnsp = 1'b1;
				tx_tcode_in     = 8'h3c;
			end
		end
		report_test("null_phase");

		send_fct_tx = 1'b1;
		fct_enabled = 1'b1;
		for (k = 0; k < traffic_cycles; k++)
		begin
			next_cycle();
			drive_inputs(1'b1);
		end
		report_test("traffic");

		while (process_data || tcode_rdy_trnsp || exp_words.size() != 0 ||
			exp_tcodes.size() != 0 || n_fct_dec != fct_pulses)
		begin
			next_cycle();
			drive_inputs(1'b0);
		end
		repeat (30)
			next_cycle();
		report_test("drain");

		// Current character finishes, then the lines hold
		send_null_tx = 1'b0;
		expect_flow  = 1'b0;
		repeat (40)
			next_cycle();
		held_d = tx_dout;
		held_s = tx_sout;
		repeat (20)
		begin
			next_cycle();
			n_checks++;
			assert (tx_dout == held_d && tx_sout == held_s)
			else
				note_error("Lines moved after the link was stopped");
		end
		n_checks++;
		assert (bitq.size() == 0 && !esc_pending)
		else
			note_error("Link stopped in the middle of a character");
		n_checks++;
		assert (exp_words.size() == 0 && exp_tcodes.size() == 0)
		else
			note_error("Taken words or time-codes never reached the line");
		n_checks++;
		assert (n_fct_dec == fct_pulses)
		else
			note_error($sformatf("Error: FCT count 0x%h, expected send_fct_now pulses 0x%h",
				n_fct_dec, fct_pulses));
		report_test("stop");

		$display("Checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* src/spw_tx_consts.svh */
`ifndef SPW_TX_CONSTS_SVH
`define SPW_TX_CONSTS_SVH

// --------------------------------------------------
// Field widths
// --------------------------------------------------
`define SPW_DATA_W          8
// Control flag plus one byte
`define SPW_NCHAR_W         9
`define SPW_TCODE_W         8
`define SPW_CREDIT_W        6
`define SPW_CREDIT_PER_FCT  8
// Highest credit a receiver may grant
`define SPW_CREDIT_MAX      56
`define SPW_FCT_PEND_W      3
`define SPW_BITCNT_W        4

// --------------------------------------------------
// Character lengths in bits
// --------------------------------------------------
`define SPW_LEN_NULL        8
`define SPW_LEN_FCT         4
`define SPW_LEN_EOP         4
`define SPW_LEN_DATA        10
`define SPW_LEN_TIMEC       14

// Control codes after parity and flag, bit 0 goes out first
`define SPW_CODE_FCT        2'b00
`define SPW_CODE_EOP        2'b10
`define SPW_CODE_EEP        2'b01
`define SPW_CODE_ESC        2'b11

`endif

/* src/spw_tx_pkg.sv */
`include "spw_tx_consts.svh"

package spw_tx_pkg;

	// --------------------------------------------------
	// Character kinds handed from scheduler to serializer
	// --------------------------------------------------
	// CK_IDLE tells the serializer to stop at the next boundary
	typedef enum logic [2:0]
	{
		CK_NULL  = 3'd0,
		CK_FCT   = 3'd1,
		CK_EOP   = 3'd2,
		CK_EEP   = 3'd3,
		CK_DATA  = 3'd4,
		CK_TIMEC = 3'd5,
		CK_IDLE  = 3'd7
	} char_kind_t;

	// Counter types
	typedef logic [`SPW_CREDIT_W-1:0]   credit_t;
	typedef logic [`SPW_FCT_PEND_W-1:0] fct_pend_t;

	// Bit position inside one character
	typedef logic [`SPW_BITCNT_W-1:0]   bit_cnt_t;

endpackage

/* src/tx_char_scheduler.sv */
`include "spw_tx_consts.svh"

module tx_char_scheduler (
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    send_null_tx,
	input  logic                    send_fct_tx,
	input  logic [`SPW_NCHAR_W-1:0] tx_data_in,
	input  logic                    process_data,
	input  logic [`SPW_TCODE_W-1:0] tx_tcode_in,
	input  logic                    tcode_rdy_trnsp,
	input  spw_tx_pkg::credit_t     credit,
	input  spw_tx_pkg::fct_pend_t   fct_pending,
	input  logic                    char_end,
	output spw_tx_pkg::char_kind_t  next_kind,
	output logic [`SPW_DATA_W-1:0]  next_payload,
	output logic                    ready_tx_data,
	output logic                    ready_tx_timecode,
	output logic                    char_sent,
	output logic                    fct_sent
);
	import spw_tx_pkg::*;

	typedef enum logic {ST_IDLE, ST_RUN} sched_state_t;

	sched_state_t state;
	char_kind_t   pick_kind;
	char_kind_t   data_kind;
	logic         take_tc;
	logic         take_fct;
	logic         take_data;

	// Flag set means EOP or EEP in the low bits
	always_comb
	begin
		if (!tx_data_in[`SPW_DATA_W])
			data_kind = CK_DATA;
		else if (tx_data_in[0])
			data_kind = CK_EEP;
		else
			data_kind = CK_EOP;
	end

	// --------------------------------------------------
	// Priority: time-code, FCT, N-char, then NULL
	// --------------------------------------------------
	always_comb
	begin
		pick_kind = CK_NULL;
		take_tc   = 1'b0;
		take_fct  = 1'b0;
		take_data = 1'b0;
		if (send_fct_tx)
		begin
			if (tcode_rdy_trnsp)
			begin
				pick_kind = CK_TIMEC;
				take_tc   = 1'b1;
			end
			else if (fct_pending != '0)
			begin
				pick_kind = CK_FCT;
				take_fct  = 1'b1;
			end
			else if (process_data && credit != '0)
			begin
				pick_kind = data_kind;
				take_data = 1'b1;
			end
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state             <= ST_IDLE;
			next_kind         <= CK_IDLE;
			ready_tx_data     <= 1'b0;
			ready_tx_timecode <= 1'b0;
			char_sent         <= 1'b0;
			fct_sent          <= 1'b0;
		end
		else
		begin
			ready_tx_data     <= 1'b0;
			ready_tx_timecode <= 1'b0;
			char_sent         <= 1'b0;
			fct_sent          <= 1'b0;
			case (state)
			ST_IDLE:
			begin
				// Link always opens with a NULL
				if (send_null_tx)
				begin
					state     <= ST_RUN;
					next_kind <= CK_NULL;
				end
			end
			default:
			begin
				if (char_end)
				begin
					if (!send_null_tx)
					begin
						state     <= ST_IDLE;
						next_kind <= CK_IDLE;
					end
					else
					begin
						next_kind         <= pick_kind;
						ready_tx_data     <= take_data;
						ready_tx_timecode <= take_tc;
						char_sent         <= take_data;
						fct_sent          <= take_fct;
					end
				end
			end
			endcase
		end
	end

	// Payload latched at the same boundary as the choice
	always_ff @(posedge pclk_tx)
	begin
		if (char_end && state == ST_RUN)
			next_payload <= take_tc ? tx_tcode_in : tx_data_in[`SPW_DATA_W-1:0];
	end

	// Source may only present EOP (00) or EEP (01) with the flag set
	a_ctrl_legal: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_tx_data |-> !($past(tx_data_in[`SPW_DATA_W]) && $past(tx_data_in[1])))
		else $error("illegal control value taken from data port");

endmodule

/* src/tx_ds_encoder.sv */
module tx_ds_encoder (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic bit_out,
	input  logic bit_valid,
	output logic tx_dout,
	output logic tx_sout
);

	// --------------------------------------------------
	// Data-strobe line encoding
	// --------------------------------------------------
	// Strobe flips only when data repeats, so one line moves per bit
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			tx_dout <= 1'b0;
			tx_sout <= 1'b0;
		end
		else if (bit_valid)
		begin
			tx_dout <= bit_out;
			if (bit_out == tx_dout)
				tx_sout <= ~tx_sout;
		end
	end

endmodule

/* src/tx_spw_top.sv */
`include "spw_tx_consts.svh"

module tx_spw_top (
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    send_null_tx,
	input  logic                    send_fct_tx,
	input  logic [`SPW_NCHAR_W-1:0] tx_data_in,
	input  logic                    process_data,
	input  logic                    gotfct_tx,
	input  logic                    send_fct_now,
	input  logic [`SPW_TCODE_W-1:0] tx_tcode_in,
	input  logic                    tcode_rdy_trnsp,
	output logic                    ready_tx_data,
	output logic                    ready_tx_timecode,
	output spw_tx_pkg::credit_t     fct_counter_p,
	output logic                    tx_dout,
	output logic                    tx_sout
);
	import spw_tx_pkg::*;

	fct_pend_t              fct_pending;
	char_kind_t             next_kind;
	logic [`SPW_DATA_W-1:0] next_payload;
	logic                   char_end;
	logic                   char_sent;
	logic                   fct_sent;
	logic                   bit_out;
	logic                   bit_valid;

	// --------------------------------------------------
	// Credit and pending FCT counters
	// --------------------------------------------------
	tx_token_counter #(
		.count_t  (credit_t),
		.add_step (`SPW_CREDIT_PER_FCT),
		.limit    (`SPW_CREDIT_MAX)
	) credit_cnt_i (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.add       (gotfct_tx),
		.take      (char_sent),
		.count     (fct_counter_p)
	);

	tx_token_counter #(
		.count_t  (fct_pend_t),
		.add_step (1)
	) fct_pend_i (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.add       (send_fct_now),
		.take      (fct_sent),
		.count     (fct_pending)
	);

	// --------------------------------------------------
	// Scheduler, serializer, line encoder
	// --------------------------------------------------
	tx_char_scheduler sched_i (
		.pclk_tx           (pclk_tx),
		.enable_tx         (enable_tx),
		.send_null_tx      (send_null_tx),
		.send_fct_tx       (send_fct_tx),
		.tx_data_in        (tx_data_in),
		.process_data      (process_data),
		.tx_tcode_in       (tx_tcode_in),
		.tcode_rdy_trnsp   (tcode_rdy_trnsp),
		.credit            (fct_counter_p),
		.fct_pending       (fct_pending),
		.char_end          (char_end),
		.next_kind         (next_kind),
		.next_payload      (next_payload),
		.ready_tx_data     (ready_tx_data),
		.ready_tx_timecode (ready_tx_timecode),
		.char_sent         (char_sent),
		.fct_sent          (fct_sent)
	);

	tx_symbol_serializer ser_i (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.next_kind    (next_kind),
		.next_payload (next_payload),
		.char_end     (char_end),
		.bit_out      (bit_out),
		.bit_valid    (bit_valid)
	);

	tx_ds_encoder ds_i (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.bit_out   (bit_out),
		.bit_valid (bit_valid),
		.tx_dout   (tx_dout),
		.tx_sout   (tx_sout)
	);

endmodule

/* src/tx_symbol_serializer.sv */
`include "spw_tx_consts.svh"

module tx_symbol_serializer (
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  spw_tx_pkg::char_kind_t next_kind,
	input  logic [`SPW_DATA_W-1:0] next_payload,
	output logic                   char_end,
	output logic                   bit_out,
	output logic                   bit_valid
);
	import spw_tx_pkg::*;

	localparam logic esc_par = ^`SPW_CODE_ESC;

	logic                      busy;
	bit_cnt_t                  bit_cnt;
	bit_cnt_t                  last_idx;
	logic                      data_par;
	logic [`SPW_LEN_TIMEC-1:0] shreg;
	logic [`SPW_LEN_TIMEC-1:0] pattern;
	bit_cnt_t                  pat_last;
	logic                      pat_par;
	logic                      load_go;

	assign char_end  = busy && (bit_cnt == last_idx);
	assign bit_out   = shreg[0];
	assign bit_valid = busy;
	assign load_go   = (!busy || char_end) && (next_kind != CK_IDLE);

	// --------------------------------------------------
	// Character image, parity in bit 0
	// --------------------------------------------------
	// data_par still holds the data bits of the character on the line
	always_comb
	begin
		pattern  = '0;
		pat_last = '0;
		pat_par  = data_par;
		case (next_kind)
		CK_NULL:
		begin
			pattern[`SPW_LEN_NULL-1:0] = {`SPW_CODE_FCT, 1'b1, ~(esc_par ^ 1'b1),
				`SPW_CODE_ESC, 1'b1, data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_NULL - 1);
			pat_par  = ^`SPW_CODE_FCT;
		end
		CK_FCT:
		begin
			pattern[`SPW_LEN_FCT-1:0] = {`SPW_CODE_FCT, 1'b1, data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_FCT - 1);
			pat_par  = ^`SPW_CODE_FCT;
		end
		CK_EOP:
		begin
			pattern[`SPW_LEN_EOP-1:0] = {`SPW_CODE_EOP, 1'b1, data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_EOP - 1);
			pat_par  = ^`SPW_CODE_EOP;
		end
		CK_EEP:
		begin
			pattern[`SPW_LEN_EOP-1:0] = {`SPW_CODE_EEP, 1'b1, data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_EOP - 1);
			pat_par  = ^`SPW_CODE_EEP;
		end
		CK_DATA:
		begin
			pattern[`SPW_LEN_DATA-1:0] = {next_payload, 1'b0, ~data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_DATA - 1);
			pat_par  = ^next_payload;
		end
		CK_TIMEC:
		begin
			// ESC then a data character carrying the time
			pattern  = {next_payload, 1'b0, ~esc_par, `SPW_CODE_ESC, 1'b1, data_par};
			pat_last = bit_cnt_t'(`SPW_LEN_TIMEC - 1);
			pat_par  = ^next_payload;
		end
		default:
		begin
			pattern = '0;
		end
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			last_idx <= '0;
			data_par <= 1'b0;
		end
		else if (load_go)
		begin
			busy     <= 1'b1;
			bit_cnt  <= '0;
			last_idx <= pat_last;
			data_par <= pat_par;
		end
		else if (char_end)
			busy <= 1'b0;
		else if (busy)
			bit_cnt <= bit_cnt + 1'b1;
	end

	// Shifted out LSB first
	always_ff @(posedge pclk_tx)
	begin
		if (load_go)
			shreg <= pattern;
		else
			shreg <= shreg >> 1;
	end

	// Boundary must fall exactly one character length after the load
	a_len_null: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(load_go && next_kind == CK_NULL) |-> ##(`SPW_LEN_NULL) char_end)
		else $error("NULL length mismatch");
	a_len_fct: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(load_go && next_kind == CK_FCT) |-> ##(`SPW_LEN_FCT) char_end)
		else $error("FCT length mismatch");
	a_len_eop: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(load_go && next_kind inside {CK_EOP, CK_EEP}) |-> ##(`SPW_LEN_EOP) char_end)
		else $error("EOP/EEP length mismatch");
	a_len_data: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(load_go && next_kind == CK_DATA) |-> ##(`SPW_LEN_DATA) char_end)
		else $error("data character length mismatch");
	a_len_timec: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(load_go && next_kind == CK_TIMEC) |-> ##(`SPW_LEN_TIMEC) char_end)
		else $error("time-code length mismatch");

endmodule

/* src/tx_token_counter.sv */
module tx_token_counter #(
	parameter type count_t  = logic [3:0],
	parameter int  add_step = 1,
	parameter int  limit    = (1 << $bits(count_t)) - 1
) (
	input  logic   pclk_tx,
	input  logic   enable_tx,
	input  logic   add,
	input  logic   take,
	output count_t count
);

	int sum;

	// Add and take may land in the same cycle
	always_comb
	begin
		sum = int'(count);
		if (add)
			sum = sum + add_step;
		if (take)
			sum = sum - 1;
		if (sum > limit)
			sum = limit;
		else if (sum < 0)
			sum = 0;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			count <= '0;
		else
			count <= count_t'(sum);
	end

	// Consumer only takes a token it saw at its last decision
	a_no_underflow: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		take |-> count != '0)
		else $error("token taken from empty counter");

	// Single requests merge at the limit, bulk grants must never be clipped
	a_no_overflow: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(add && add_step > 1) |-> (int'(count) + add_step - int'(take)) <= limit)
		else $error("token grant beyond limit");

endmodule

/* tx_spw_top.f */
+incdir+src
src/spw_tx_pkg.sv
src/tx_token_counter.sv
src/tx_char_scheduler.sv
src/tx_symbol_serializer.sv
src/tx_ds_encoder.sv
src/tx_spw_top.sv
sim/tb_tx_spw_top.sv
